// ==== design/aq_accum_buffer.sv ====
`timescale 1ns/1ps

module aq_accum_buffer #(
  parameter int unsigned NUM_ACC   = aq_cfg_pkg::NUM_ACC,
  parameter int unsigned ACC_WIDTH = aq_cfg_pkg::ACC_WIDTH
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  aq_ctrl_pkg::buf_op_e                      buf_op_i,
  input  logic [$clog2(NUM_ACC)-1:0]                buf_addr_i,
  input  logic signed [ACC_WIDTH-1:0]               operand_i,
  input  logic                                      wb_valid_i,
  input  logic [$clog2(NUM_ACC)-1:0]                wb_addr_i,
  input  logic [ACC_WIDTH-1:0]                      wb_data_i,
  output logic signed [ACC_WIDTH-1:0]               rd_data_o,
  output logic [NUM_ACC*aq_cfg_pkg::QOUT_WIDTH-1:0] packed_o
);

  import aq_cfg_pkg::*;
  import aq_ctrl_pkg::*;

  logic signed [ACC_WIDTH-1:0] acc_q [NUM_ACC];
  logic signed [ACC_WIDTH-1:0] sum;

  assign rd_data_o = acc_q[buf_addr_i];
  assign sum       = rd_data_o + operand_i;  // wraps on overflow

  // ====================================================================
  // register bank
  // ====================================================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NUM_ACC; i++) begin
        acc_q[i] <= '0;
      end
    end else if (buf_op_i == BUF_CLEAR) begin
      for (int unsigned i = 0; i < NUM_ACC; i++) begin
        acc_q[i] <= '0;
      end
    end else begin
      if (buf_op_i == BUF_ADD) begin
        acc_q[buf_addr_i] <= sum;
      end
      // writeback comes last so it overrides a same-address add
      if (wb_valid_i) begin
        acc_q[wb_addr_i] <= wb_data_i;
      end
    end
  end

  // low byte of every lane for stream-out
  for (genvar g = 0; g < NUM_ACC; g++) begin : g_pack
    assign packed_o[g*QOUT_WIDTH +: QOUT_WIDTH] = acc_q[g][QOUT_WIDTH-1:0];
  end

endmodule

// ==== design/aq_cfg_pkg.sv ====
package aq_cfg_pkg;

  // ====================================================================
  // accumulator bank sizing
  // ====================================================================

  localparam int unsigned NUM_ACC   = 8;   // accumulators in the bank
  localparam int unsigned ACC_WIDTH = 32;  // signed accumulator width

  // normquant and stream-out widths
  localparam int unsigned QOUT_WIDTH  = 8;   // one quantized output byte
  localparam int unsigned SCALE_WIDTH = 8;   // unsigned per-lane scale
  localparam int unsigned SHIFT_WIDTH = 5;   // global right shift

  // command length fields
  localparam int unsigned LEN_WIDTH = 16;

  // register stages between issue and writeback
  localparam int unsigned NQ_LATENCY = 2;

endpackage

// ==== design/aq_controller.sv ====
`timescale 1ns/1ps

module aq_controller #(
  parameter int unsigned NUM_ACC = aq_cfg_pkg::NUM_ACC
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  aq_ctrl_pkg::aq_cmd_e             cmd_i,
  input  logic [aq_cfg_pkg::LEN_WIDTH-1:0] full_len_i,
  input  logic                             conv_valid_i,
  output logic                             conv_ready_o,
  output logic                             norm_ready_o,
  input  logic                             norm_valid_i,
  output logic                             out_valid_o,
  input  logic                             out_ready_i,
  output logic                             busy_o,
  output aq_ctrl_pkg::buf_op_e             buf_op_o,
  output logic [$clog2(NUM_ACC)-1:0]       buf_addr_o,
  aq_nq_if.ctrl                            nq
);

  import aq_cfg_pkg::*;
  import aq_ctrl_pkg::*;

  localparam int unsigned AW = $clog2(NUM_ACC);

  aq_state_e            state_q, state_d;
  logic [AW-1:0]        addr_q, addr_d;
  logic [LEN_WIDTH-1:0] cnt_q, cnt_d;
  logic [LEN_WIDTH-1:0] last_cnt;
  logic                 addr_wrap;
  logic                 conv_hs;

  assign last_cnt  = (full_len_i == '0) ? '0 : full_len_i - 1'b1;  // zero length means one
  assign addr_wrap = (addr_q == AW'(NUM_ACC - 1));
  assign conv_hs   = conv_ready_o && conv_valid_i;

  // ====================================================================
  // next state and counters
  // ====================================================================

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    cnt_d   = cnt_q;
    case (state_q)
      AQ_IDLE: begin
        addr_d = '0;
        cnt_d  = '0;
        case (cmd_i)
          CMD_ACCUM:     state_d = AQ_ACCUM;
          CMD_NORMQUANT: state_d = AQ_NQ_LOAD;
          CMD_STREAMOUT: state_d = AQ_STREAMOUT;
          default:       state_d = AQ_IDLE;
        endcase
      end
      AQ_ACCUM: begin
        if (conv_hs) begin
          addr_d = addr_wrap ? '0 : addr_q + 1'b1;
          cnt_d  = cnt_q + 1'b1;
          if (cnt_q == last_cnt) begin
            state_d = AQ_IDLE;  // done on the last handshake edge
          end
        end
      end
      AQ_NQ_LOAD: begin
        if (norm_valid_i) begin
          state_d = AQ_NQ_ISSUE;
        end
      end
      AQ_NQ_ISSUE: begin
        addr_d = addr_wrap ? '0 : addr_q + 1'b1;
        if (addr_wrap) begin
          state_d = AQ_NQ_DRAIN;
        end
      end
      AQ_NQ_DRAIN: begin
        if (!nq.inflight) begin
          state_d = AQ_IDLE;  // final writeback lands on this edge
        end
      end
      AQ_STREAMOUT: begin
        if (out_ready_i) begin
          state_d = AQ_IDLE;
        end
      end
      default: state_d = AQ_IDLE;
    endcase

    // clear wins in every state
    if (clear_i) begin
      state_d = AQ_IDLE;
      addr_d  = '0;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AQ_IDLE;
      addr_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      cnt_q   <= cnt_d;
    end
  end

  // ====================================================================
  // outputs
  // ====================================================================

  assign conv_ready_o = (state_q == AQ_ACCUM);
  assign norm_ready_o = (state_q == AQ_NQ_LOAD);
  assign out_valid_o  = (state_q == AQ_STREAMOUT);
  assign busy_o       = (state_q != AQ_IDLE);
  assign buf_addr_o   = addr_q;  // add target and normquant read share it

  assign nq.scale_load  = norm_ready_o && norm_valid_i;
  assign nq.issue_valid = (state_q == AQ_NQ_ISSUE);
  assign nq.issue_addr  = addr_q;

  always_comb begin
    if (clear_i) begin
      buf_op_o = BUF_CLEAR;
    end else if (conv_hs) begin
      buf_op_o = BUF_ADD;
    end else begin
      buf_op_o = BUF_NOP;
    end
  end

endmodule

// ==== design/aq_ctrl_pkg.sv ====
package aq_ctrl_pkg;

  // single-cycle command strobes, sampled in idle only
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_ACCUM,
    CMD_NORMQUANT,
    CMD_STREAMOUT
  } aq_cmd_e;

  typedef enum logic [2:0] {
    AQ_IDLE,
    AQ_ACCUM,
    AQ_NQ_LOAD,    // waiting for the scale beat
    AQ_NQ_ISSUE,   // one accumulator per cycle into the pipe
    AQ_NQ_DRAIN,   // last items still in flight
    AQ_STREAMOUT
  } aq_state_e;

  // operation on the accumulator bank
  typedef enum logic [1:0] {
    BUF_NOP,
    BUF_ADD,
    BUF_CLEAR
  } buf_op_e;

endpackage

// ==== design/aq_normquant.sv ====
`timescale 1ns/1ps

module aq_normquant #(
  parameter int unsigned NUM_ACC   = aq_cfg_pkg::NUM_ACC,
  parameter int unsigned ACC_WIDTH = aq_cfg_pkg::ACC_WIDTH
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       clear_i,
  input  logic [NUM_ACC*aq_cfg_pkg::SCALE_WIDTH-1:0] norm_data_i,
  input  logic [aq_cfg_pkg::SHIFT_WIDTH-1:0]         right_shift_i,
  input  logic signed [ACC_WIDTH-1:0]                acc_i,
  aq_nq_if.nq                                        nq,
  output logic                                       wb_valid_o,
  output logic [$clog2(NUM_ACC)-1:0]                 wb_addr_o,
  output logic [ACC_WIDTH-1:0]                       wb_data_o
);

  import aq_cfg_pkg::*;

  localparam int unsigned AW = $clog2(NUM_ACC);
  localparam int unsigned PW = ACC_WIDTH + SCALE_WIDTH + 1;  // signed product

  logic [NUM_ACC-1:0][SCALE_WIDTH-1:0] scale_q;
  logic signed [SCALE_WIDTH:0]         scale_sel;
  logic signed [PW-1:0]                prod;
  logic signed [PW-1:0]                s1_prod_q;
  logic signed [PW-1:0]                shifted;
  logic [QOUT_WIDTH-1:0]               clipped;
  logic [QOUT_WIDTH-1:0]               s2_data_q;
  logic [AW-1:0]                       s1_addr_q, s2_addr_q;
  logic                                s1_vld_q, s2_vld_q;

  always_ff @(posedge clk_i) begin
    if (nq.scale_load) begin
      scale_q <= norm_data_i;  // lane i in byte i
    end
  end

  // ====================================================================
  // stage 1 multiply, stage 2 shift and clip
  // ====================================================================

  assign scale_sel = $signed({1'b0, scale_q[nq.issue_addr]});
  assign prod      = acc_i * scale_sel;
  assign shifted   = s1_prod_q >>> right_shift_i;

  always_comb begin
    if (shifted[PW-1]) begin
      clipped = '0;  // negative floor
    end else if (|shifted[PW-2:QOUT_WIDTH]) begin
      clipped = '1;  // saturate at 255
    end else begin
      clipped = shifted[QOUT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else if (clear_i) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= nq.issue_valid;
      s2_vld_q <= s1_vld_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (nq.issue_valid) begin
      s1_prod_q <= prod;
      s1_addr_q <= nq.issue_addr;
    end
    if (s1_vld_q) begin
      s2_data_q <= clipped;
      s2_addr_q <= s1_addr_q;
    end
  end

  assign wb_valid_o = s2_vld_q;
  assign wb_addr_o  = s2_addr_q;
  assign wb_data_o  = ACC_WIDTH'(s2_data_q);  // zero-extended byte

  // stage 2 item retires on this edge, only stage 1 is still owed
  assign nq.inflight = s1_vld_q;

endmodule

// ==== design/aq_nq_if.sv ====
`timescale 1ns/1ps

interface aq_nq_if #(
  parameter int unsigned NUM_ACC = aq_cfg_pkg::NUM_ACC
);

  logic                       scale_load;   // latch the scale beat
  logic                       issue_valid;  // one accumulator enters stage 1
  logic [$clog2(NUM_ACC)-1:0] issue_addr;
  logic                       inflight;     // pipe still owes a writeback

  modport ctrl (
    output scale_load,
    output issue_valid,
    output issue_addr,
    input  inflight
  );

  modport nq (
    input  scale_load,
    input  issue_valid,
    input  issue_addr,
    output inflight
  );

endinterface

// ==== design/aq_top.sv ====
`timescale 1ns/1ps

module aq_top #(
  parameter int unsigned NUM_ACC   = aq_cfg_pkg::NUM_ACC,
  parameter int unsigned ACC_WIDTH = aq_cfg_pkg::ACC_WIDTH
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // commands and configuration
  input  logic                                       clear_i,
  input  aq_ctrl_pkg::aq_cmd_e                       cmd_i,
  input  logic [aq_cfg_pkg::LEN_WIDTH-1:0]           full_len_i,
  input  logic [aq_cfg_pkg::SHIFT_WIDTH-1:0]         right_shift_i,
  input  logic [aq_cfg_pkg::LEN_WIDTH-1:0]           out_len_i,
  // partial sums
  input  logic                                       conv_valid_i,
  input  logic signed [ACC_WIDTH-1:0]                conv_data_i,
  output logic                                       conv_ready_o,
  // scales
  input  logic                                       norm_valid_i,
  input  logic [NUM_ACC*aq_cfg_pkg::SCALE_WIDTH-1:0] norm_data_i,
  output logic                                       norm_ready_o,
  // quantized output
  output logic                                       out_valid_o,
  input  logic                                       out_ready_i,
  output logic [NUM_ACC*aq_cfg_pkg::QOUT_WIDTH-1:0]  out_data_o,
  output logic [NUM_ACC-1:0]                         out_strb_o,
  output logic                                       busy_o
);

  import aq_ctrl_pkg::*;

  localparam int unsigned AW = $clog2(NUM_ACC);

  buf_op_e                     buf_op;
  logic [AW-1:0]               buf_addr;
  logic signed [ACC_WIDTH-1:0] rd_data;
  logic                        wb_valid;
  logic [AW-1:0]               wb_addr;
  logic [ACC_WIDTH-1:0]        wb_data;

  aq_nq_if #(.NUM_ACC(NUM_ACC)) nq_if ();

  aq_controller #(.NUM_ACC(NUM_ACC)) i_ctrl (
    .clk_i, .rst_ni, .clear_i, .cmd_i, .full_len_i,
    .conv_valid_i, .conv_ready_o, .norm_ready_o, .norm_valid_i,
    .out_valid_o, .out_ready_i, .busy_o,
    .buf_op_o   (buf_op),
    .buf_addr_o (buf_addr),
    .nq         (nq_if.ctrl)
  );

  aq_accum_buffer #(.NUM_ACC(NUM_ACC), .ACC_WIDTH(ACC_WIDTH)) i_buf (
    .clk_i, .rst_ni,
    .buf_op_i   (buf_op),
    .buf_addr_i (buf_addr),
    .operand_i  (conv_data_i),  // partial sum goes straight to the adder
    .wb_valid_i (wb_valid),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data),
    .rd_data_o  (rd_data),
    .packed_o   (out_data_o)
  );

  aq_normquant #(.NUM_ACC(NUM_ACC), .ACC_WIDTH(ACC_WIDTH)) i_nq (
    .clk_i, .rst_ni, .clear_i, .norm_data_i, .right_shift_i,
    .acc_i      (rd_data),
    .nq         (nq_if.nq),
    .wb_valid_o (wb_valid),
    .wb_addr_o  (wb_addr),
    .wb_data_o  (wb_data)
  );

  // lowest out_len_i lanes, all lanes for zero or oversize length
  always_comb begin
    for (int unsigned i = 0; i < NUM_ACC; i++) begin
      out_strb_o[i] = (out_len_i == '0) || (i < out_len_i);
    end
  end

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned HALF_PERIOD_NS = 2,   // 4 ns clock
  parameter int unsigned RESET_CYCLES   = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // release away from the active edge
  end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

  import aq_cfg_pkg::*;
  import aq_ctrl_pkg::*;

  localparam int unsigned MAX_LEN      = 24;  // longest accumulation command
  localparam int unsigned MAX_GAP      = 3;   // idle cycles between partial sums
  localparam int unsigned MAX_STALL    = 8;
  localparam int unsigned NO_CLEAR     = 32'hffff_ffff;
  localparam int unsigned ACCUM_CYCLES = MAX_LEN * (MAX_GAP + 1) + 4;
  localparam int unsigned NQ_CYCLES    = NUM_ACC + NQ_LATENCY + 6;
  localparam int unsigned OUT_CYCLES   = MAX_STALL + 4;
  // 4 accumulations, 2 normquant runs, 9 stream-outs and the reset
  localparam int unsigned CYCLE_LIMIT  = 2 * (12 + 4 * ACCUM_CYCLES + 2 * NQ_CYCLES
                                              + 9 * OUT_CYCLES);

  logic                           clk, rst_n, clear;
  aq_cmd_e                        cmd;
  logic [LEN_WIDTH-1:0]           full_len, out_len;
  logic [SHIFT_WIDTH-1:0]         right_shift;
  logic                           conv_valid, conv_ready;
  logic signed [ACC_WIDTH-1:0]    conv_data;
  logic                           norm_valid, norm_ready;
  logic [NUM_ACC*SCALE_WIDTH-1:0] norm_data;
  logic                           out_valid, out_ready, busy;
  logic [NUM_ACC*QOUT_WIDTH-1:0]  out_data, exp_data, stall_data;
  logic [NUM_ACC-1:0]             out_strb, exp_strb;
  logic                           stalled;

  logic signed [ACC_WIDTH-1:0] ref_acc [NUM_ACC];  // reference model of the bank
  logic signed [ACC_WIDTH-1:0] target  [NUM_ACC];
  logic [31:0]                 lfsr;
  int unsigned                 errors, checks, out_beats, cycles;

  tb_clkgen i_clkgen (.clk_o(clk), .rst_no(rst_n));

  aq_top #(.NUM_ACC(NUM_ACC), .ACC_WIDTH(ACC_WIDTH)) uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .clear_i       (clear),
    .cmd_i         (cmd),
    .full_len_i    (full_len),
    .right_shift_i (right_shift),
    .out_len_i     (out_len),
    .conv_valid_i  (conv_valid),
    .conv_data_i   (conv_data),
    .conv_ready_o  (conv_ready),
    .norm_valid_i  (norm_valid),
    .norm_data_i   (norm_data),
    .norm_ready_o  (norm_ready),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .out_data_o    (out_data),
    .out_strb_o    (out_strb),
    .busy_o        (busy)
  );

  // ====================================================================
  // random bits and reference functions
  // ====================================================================

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};  // galois step per bit
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [QOUT_WIDTH-1:0] quantize(input logic signed [ACC_WIDTH-1:0] acc,
                                                     input logic [SCALE_WIDTH-1:0] scale,
                                                     input logic [SHIFT_WIDTH-1:0] shift);
    longint prod;
    prod = longint'(acc) * longint'({1'b0, scale});
    prod = prod >>> shift;
    if (prod < 0) begin
      return '0;
    end else if (prod > longint'(2 ** QOUT_WIDTH - 1)) begin
      return '1;
    end
    return prod[QOUT_WIDTH-1:0];
  endfunction

  function automatic logic [NUM_ACC-1:0] strobe_mask(input int unsigned len);
    if (len == 0 || len >= NUM_ACC) begin
      return '1;
    end
    return (NUM_ACC'(1) << len) - 1'b1;
  endfunction

  function automatic logic [NUM_ACC*QOUT_WIDTH-1:0] low_bytes();
    logic [NUM_ACC*QOUT_WIDTH-1:0] r;
    for (int i = 0; i < NUM_ACC; i++) begin
      r[i*QOUT_WIDTH +: QOUT_WIDTH] = ref_acc[i][QOUT_WIDTH-1:0];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    errors++;
    $display("FAIL %s expected %h got %h at %0t", name, exp_v, act_v, $time);
  endtask

  // ====================================================================
  // stimulus tasks, all driving on the falling edge
  // ====================================================================

  task automatic issue_cmd(input aq_cmd_e c);
    @(negedge clk);
    cmd = c;
    @(negedge clk);
    cmd = CMD_NONE;  // command now owns the state machine
  endtask

  task automatic accumulate(input int unsigned len, input int unsigned clear_at,
                            input logic use_target);
    int unsigned                 beats, a;
    logic [31:0]                 r;
    logic signed [ACC_WIDTH-1:0] data;
    beats    = (len == 0) ? 1 : len;
    full_len = LEN_WIDTH'(len);
    issue_cmd(CMD_ACCUM);
    for (int unsigned k = 0; k < beats; k++) begin
      conv_valid = 1'b0;
      repeat (rand_bits(2)) @(negedge clk);
      a = k % NUM_ACC;
      r = rand_bits(12);
      data = use_target ? target[a] - ref_acc[a] : {{(ACC_WIDTH-12){r[11]}}, r[11:0]};
      conv_valid = 1'b1;
      conv_data  = data;
      if (k == clear_at) begin
        clear = 1'b1;  // clear beats the pending add
        @(negedge clk);
        clear      = 1'b0;
        conv_valid = 1'b0;
        for (int i = 0; i < NUM_ACC; i++) ref_acc[i] = '0;
        if (busy !== 1'b0) begin
          errors++;
          $display("busy_o still high one cycle after clear_i");
        end
        return;
      end
      if (conv_ready !== 1'b1) begin
        errors++;
        $display("conv_ready_o low during accumulation at %0t", $time);
      end
      @(negedge clk);
      ref_acc[a] = ref_acc[a] + data;
    end
    conv_valid = 1'b0;
    if (conv_ready !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("accumulation did not end after partial sum %0d", beats);
    end
  endtask

  task automatic run_normquant(input logic [NUM_ACC*SCALE_WIDTH-1:0] scales,
                               input logic [SHIFT_WIDTH-1:0] shift);
    int unsigned n;
    right_shift = shift;
    norm_data   = scales;
    issue_cmd(CMD_NORMQUANT);
    if (norm_ready !== 1'b1) begin
      errors++;
      $display("norm_ready_o not raised after CMD_NORMQUANT");
    end
    norm_valid = 1'b1;
    @(negedge clk);  // scale handshake on the edge just passed
    norm_valid = 1'b0;
    for (int i = 0; i < NUM_ACC; i++) begin
      ref_acc[i] = {{(ACC_WIDTH-QOUT_WIDTH){1'b0}},
                    quantize(ref_acc[i], scales[i*SCALE_WIDTH +: SCALE_WIDTH], shift)};
    end
    n = 0;
    while (busy === 1'b1 && n <= NUM_ACC + NQ_LATENCY + 2) begin
      @(negedge clk);
      n++;
    end
    if (n != NUM_ACC + NQ_LATENCY) begin
      errors++;
      $display("busy_o fell %0d cycles after the scale handshake, not %0d",
               n, NUM_ACC + NQ_LATENCY);
    end
  endtask

  task automatic stream_out(input int unsigned len, input int unsigned stall);
    int unsigned beats_before;
    out_len      = LEN_WIDTH'(len);
    exp_data     = low_bytes();
    exp_strb     = strobe_mask(len);
    beats_before = out_beats;
    out_ready    = 1'b0;
    issue_cmd(CMD_STREAMOUT);
    if (out_valid !== 1'b1) begin
      errors++;
      $display("out_valid_o not raised after CMD_STREAMOUT");
    end
    repeat (stall) @(negedge clk);
    out_ready = 1'b1;
    while (out_beats == beats_before) @(negedge clk);
    out_ready = 1'b0;
    if (out_valid !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("controller not idle after the output handshake");
    end
  endtask

  // compares each output beat and holds stalled beats to their first value
  always @(posedge clk) begin
    if (stalled) begin
      if (out_valid !== 1'b1) begin
        errors++;
        $display("out_valid_o dropped before the output handshake at %0t", $time);
      end else if (out_data !== stall_data) begin
        report_mismatch("out_data_o", 64'(stall_data), 64'(out_data));
      end
    end
    stalled    = out_valid && !out_ready && !clear;
    stall_data = out_data;
    if (out_valid === 1'b1 && out_ready === 1'b1) begin
      checks++;
      if (out_data !== exp_data) begin
        report_mismatch("out_data_o", 64'(exp_data), 64'(out_data));
      end
      if (out_strb !== exp_strb) begin
        report_mismatch("out_strb_o", 64'(exp_strb), 64'(out_strb));
      end
      out_beats++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycles);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("Done: errors found");
    $finish;
  end

  // ====================================================================
  // test sequence
  // ====================================================================

  initial begin
    logic [NUM_ACC*SCALE_WIDTH-1:0] scales;
    logic [31:0]                    r;
    clear       = 1'b0;
    cmd         = CMD_NONE;
    full_len    = '0;
    out_len     = '0;
    right_shift = '0;
    conv_valid  = 1'b0;
    conv_data   = '0;
    norm_valid  = 1'b0;
    norm_data   = '0;
    out_ready   = 1'b0;
    exp_data    = '0;
    exp_strb    = '0;
    stalled     = 1'b0;
    stall_data  = '0;
    lfsr        = 32'h65f5;
    errors      = 0;
    checks      = 0;
    out_beats   = 0;
    for (int i = 0; i < NUM_ACC; i++) begin
      ref_acc[i] = '0;
      target[i]  = '0;
    end

    wait (rst_n === 1'b1);
    @(negedge clk);
    if (conv_ready !== 1'b0 || norm_ready !== 1'b0 || out_valid !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("a ready, valid or busy output is high after reset");
    end

    // two commands, the second one wraps the address counter
    accumulate(rand_bits(4), NO_CLEAR, 1'b0);
    accumulate(rand_bits(4) + NUM_ACC, NO_CLEAR, 1'b0);
    stream_out(0, 0);

    // lane 0 clips at zero, lane 1 saturates, the rest land anywhere
    for (int i = 0; i < NUM_ACC; i++) begin
      r         = rand_bits(10);
      target[i] = ACC_WIDTH'(r[9:0]);
      scales[i*SCALE_WIDTH +: SCALE_WIDTH] = rand_bits(SCALE_WIDTH);
    end
    r         = rand_bits(12);
    target[0] = -ACC_WIDTH'(r[11:0]) - 1;
    target[1] = 100000 + ACC_WIDTH'(r[11:0]);
    scales[0 +: SCALE_WIDTH]           = 8'd1;
    scales[SCALE_WIDTH +: SCALE_WIDTH] = 8'd200;
    accumulate(NUM_ACC, NO_CLEAR, 1'b1);
    run_normquant(scales, SHIFT_WIDTH'(3 + rand_bits(3)));
    stream_out(0, 0);
    for (int i = 0; i < NUM_ACC; i++) begin
      scales[i*SCALE_WIDTH +: SCALE_WIDTH] = rand_bits(SCALE_WIDTH);
    end
    run_normquant(scales, SHIFT_WIDTH'(rand_bits(2)));
    stream_out(NUM_ACC, 0);

    // strobe masks
    stream_out(0, 0);
    stream_out(3, 0);
    stream_out(NUM_ACC, 0);
    stream_out(NUM_ACC + 5, 0);

    stream_out(rand_bits(4), 1 + rand_bits(3));  // back-pressure

    accumulate(MAX_LEN, 1 + rand_bits(2), 1'b0);  // cut short by clear
    stream_out(0, 0);

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0 && checks == 9) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the accumulator bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_top \
    -f tb.f -Mdir obj_dir -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -qx 'Done: no errors' sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// ==== tb.f ====
design/aq_cfg_pkg.sv
design/aq_ctrl_pkg.sv
design/aq_nq_if.sv
design/aq_controller.sv
design/aq_accum_buffer.sv
design/aq_normquant.sv
design/aq_top.sv
dv/tb_clkgen.sv
dv/tb_top.sv
